//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/rv_pkg.sv
package rv_pkg;

    // base opcodes
    localparam logic [6:0] OPC7_R_TYPE = 7'b011_0011;
    localparam logic [6:0] OPC7_I_TYPE = 7'b001_0011;
    localparam logic [6:0] OPC7_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC7_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC7_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC7_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC7_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC7_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC7_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OPC7_SYSTEM = 7'b111_0011;

    // alu ops, {funct7[5], funct3}
    localparam logic [3:0] ALU_ADD    = 4'b0000;
    localparam logic [3:0] ALU_SUB    = 4'b1000;
    localparam logic [3:0] ALU_SLL    = 4'b0001;
    localparam logic [3:0] ALU_SLT    = 4'b0010;
    localparam logic [3:0] ALU_SLTU   = 4'b0011;
    localparam logic [3:0] ALU_XOR    = 4'b0100;
    localparam logic [3:0] ALU_SRL    = 4'b0101;
    localparam logic [3:0] ALU_SRA    = 4'b1101;
    localparam logic [3:0] ALU_OR     = 4'b0110;
    localparam logic [3:0] ALU_AND    = 4'b0111;
    // no rv32i instruction decodes to this one
    localparam logic [3:0] ALU_PASS_B = 4'b1111;

    localparam logic ALU_A_SEL_RS1 = 1'b0;
    localparam logic ALU_A_SEL_PC  = 1'b1;
    localparam logic ALU_B_SEL_RS2 = 1'b0;
    localparam logic ALU_B_SEL_IMM = 1'b1;

    // immediate formats
    localparam logic [2:0] IG_DISABLED = 3'd0;
    localparam logic [2:0] IG_I_TYPE   = 3'd1;
    localparam logic [2:0] IG_S_TYPE   = 3'd2;
    localparam logic [2:0] IG_B_TYPE   = 3'd3;
    localparam logic [2:0] IG_U_TYPE   = 3'd4;
    localparam logic [2:0] IG_J_TYPE   = 3'd5;

    localparam logic WB_SEL_ALU  = 1'b0;
    localparam logic WB_SEL_INC4 = 1'b1;

    localparam logic [1:0] PC_SEL_START_ADDR = 2'd0;
    localparam logic [1:0] PC_SEL_INC4       = 2'd1;
    localparam logic [1:0] PC_SEL_ALU        = 2'd2;

    // branch condition from {funct3[2], funct3[0]}
    localparam logic [1:0] BR_SEL_BEQ = 2'b00;
    localparam logic [1:0] BR_SEL_BNE = 2'b01;
    localparam logic [1:0] BR_SEL_BLT = 2'b10;
    localparam logic [1:0] BR_SEL_BGE = 2'b11;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [31:0] INST_NOP = 32'h0000_0013;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    // one instruction word seen through each format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        logic [3:0] alu_op;
        logic       alu_a_sel;
        logic       alu_b_sel;
        logic [2:0] ig_sel;
        logic       bc_uns;
        logic       wb_sel;
        logic       reg_we;
        logic       branch;
        logic       jump;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] value;
    } retire_t;

endpackage

//--- decoder/rv_decoder.sv
module rv_decoder (
    input  logic          clk,
    input  logic          rst,
    input  rv_pkg::inst_u inst_id,
    input  rv_pkg::inst_u inst_ex,
    input  logic          bc_a_eq_b,
    input  logic          bc_a_lt_b,
    output rv_pkg::ctrl_t ctrl,
    output logic [1:0]    pc_sel,
    output logic          stall_if,
    output logic          flow_change,
    output logic          clear_id,
    output logic          clear_ex
);

    logic [2:0] reset_seq;
    logic       branch_ex;
    logic       jump_ex;
    logic [1:0] br_sel;
    logic       branch_taken;

    // bit k stays high for k+1 cycles after rst drops
    always_ff @(posedge clk) begin
        if (rst) begin
            reset_seq <= 3'b111;
        end else begin
            reset_seq <= {reset_seq[1:0], 1'b0};
        end
    end

    assign clear_id = reset_seq[0];
    assign clear_ex = reset_seq[1];

    // decode stage
    always_comb begin
        ctrl.alu_op    = rv_pkg::ALU_ADD;
        ctrl.alu_a_sel = rv_pkg::ALU_A_SEL_RS1;
        ctrl.alu_b_sel = rv_pkg::ALU_B_SEL_RS2;
        ctrl.ig_sel    = rv_pkg::IG_DISABLED;
        ctrl.bc_uns    = 1'b0;
        ctrl.wb_sel    = rv_pkg::WB_SEL_ALU;
        ctrl.reg_we    = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;

        case (inst_id.r.opcode)
            rv_pkg::OPC7_R_TYPE: begin
                ctrl.alu_op = {inst_id.r.funct7[5], inst_id.r.funct3};
                ctrl.reg_we = 1'b1;
            end
            rv_pkg::OPC7_I_TYPE: begin
                // only shifts carry funct7 and srai needs bit 5
                if (inst_id.r.funct3[1:0] == 2'b01) begin
                    ctrl.alu_op = {inst_id.r.funct7[5], inst_id.r.funct3};
                end else begin
                    ctrl.alu_op = {1'b0, inst_id.r.funct3};
                end
                ctrl.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                ctrl.ig_sel    = rv_pkg::IG_I_TYPE;
                ctrl.reg_we    = 1'b1;
            end
            rv_pkg::OPC7_BRANCH: begin
                // target computed as pc + imm
                ctrl.alu_a_sel = rv_pkg::ALU_A_SEL_PC;
                ctrl.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                ctrl.ig_sel    = rv_pkg::IG_B_TYPE;
                ctrl.bc_uns    = inst_id.r.funct3[1];
                ctrl.branch    = 1'b1;
            end
            rv_pkg::OPC7_JALR: begin
                ctrl.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                ctrl.ig_sel    = rv_pkg::IG_I_TYPE;
                ctrl.wb_sel    = rv_pkg::WB_SEL_INC4;
                ctrl.reg_we    = 1'b1;
                ctrl.jump      = 1'b1;
            end
            rv_pkg::OPC7_JAL: begin
                ctrl.alu_a_sel = rv_pkg::ALU_A_SEL_PC;
                ctrl.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                ctrl.ig_sel    = rv_pkg::IG_J_TYPE;
                ctrl.wb_sel    = rv_pkg::WB_SEL_INC4;
                ctrl.reg_we    = 1'b1;
                ctrl.jump      = 1'b1;
            end
            rv_pkg::OPC7_LUI: begin
                ctrl.alu_op    = rv_pkg::ALU_PASS_B;
                ctrl.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                ctrl.ig_sel    = rv_pkg::IG_U_TYPE;
                ctrl.reg_we    = 1'b1;
            end
            rv_pkg::OPC7_AUIPC: begin
                ctrl.alu_a_sel = rv_pkg::ALU_A_SEL_PC;
                ctrl.alu_b_sel = rv_pkg::ALU_B_SEL_IMM;
                ctrl.ig_sel    = rv_pkg::IG_U_TYPE;
                ctrl.reg_we    = 1'b1;
            end
            // without data memory these pass through with no write
            rv_pkg::OPC7_LOAD: begin
                ctrl.ig_sel = rv_pkg::IG_I_TYPE;
            end
            rv_pkg::OPC7_STORE: begin
                ctrl.ig_sel = rv_pkg::IG_S_TYPE;
            end
            rv_pkg::OPC7_SYSTEM: begin
                ctrl.reg_we = 1'b0;
            end
            default: begin
                ctrl.reg_we = 1'b0;
            end
        endcase

        if (inst_id.r.rd == 5'd0) begin
            ctrl.reg_we = 1'b0;
        end
    end

    // flags follow the instruction into execute
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_ex <= 1'b0;
            jump_ex   <= 1'b0;
        end else begin
            branch_ex <= ctrl.branch;
            jump_ex   <= ctrl.jump;
        end
    end

    // branch resolution in execute
    assign br_sel = {inst_ex.r.funct3[2], inst_ex.r.funct3[0]};

    always_comb begin
        case (br_sel)
            rv_pkg::BR_SEL_BEQ: branch_taken = bc_a_eq_b;
            rv_pkg::BR_SEL_BNE: branch_taken = !bc_a_eq_b;
            rv_pkg::BR_SEL_BLT: branch_taken = bc_a_lt_b;
            default:            branch_taken = !bc_a_lt_b;
        endcase
    end

    assign flow_change = (branch_ex && branch_taken) || jump_ex;

    // without prediction fetch waits for the resolve
    assign stall_if = ctrl.branch || ctrl.jump;

    assign pc_sel = clear_id    ? rv_pkg::PC_SEL_START_ADDR :
                    flow_change ? rv_pkg::PC_SEL_ALU :
                                  rv_pkg::PC_SEL_INC4;

    // covers the clear_ex window and one more cycle
    a_no_flow_in_clear: assert property (
        @(posedge clk) disable iff (rst)
        reset_seq[2] |-> !flow_change
    );

    // the core bubbles decode behind a stall so it lasts one cycle
    a_stall_single: assert property (
        @(posedge clk) disable iff (rst)
        stall_if |=> !stall_if
    );

endmodule

//--- dv/rv_checker.sv
module rv_checker (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::retire_t retire,
    input  logic [31:0]     model_inst,
    input  logic [31:0]     halt_pc,
    input  int              cycle_limit,
    output logic [31:0]     model_pc,
    output logic            done,
    output int              errors,
    output int              retired
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]     model_regs [0:31];
    rv_pkg::retire_t expected;
    int              cycles;

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $unsigned($signed(a) >>> b[4:0]);
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // one instruction of the ISA model, updates regs and pc
    function automatic rv_pkg::retire_t ref_step(input logic [31:0] word);
        rv_pkg::inst_u   inst;
        rv_pkg::retire_t exp;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_i;
        logic [31:0]     imm_b;
        logic [31:0]     imm_j;
        logic [31:0]     imm_u;
        logic [31:0]     next_pc;
        logic [31:0]     result;
        logic            wr;
        logic            take;
        inst = word;
        a = model_regs[inst.r.rs1];
        b = model_regs[inst.r.rs2];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        imm_u = {word[31:12], 12'h000};
        next_pc = model_pc + 32'd4;
        result = 32'h0000_0000;
        wr = 1'b0;
        take = 1'b0;
        case (inst.r.opcode)
            rv_pkg::OPC7_R_TYPE: begin
                result = alu_ref(inst.r.funct3, word[30], a, b);
                wr = 1'b1;
            end
            rv_pkg::OPC7_I_TYPE: begin
                // only srai uses bit 30
                result = alu_ref(inst.r.funct3, (inst.r.funct3 == 3'd5) && word[30], a, imm_i);
                wr = 1'b1;
            end
            rv_pkg::OPC7_LUI: begin
                result = imm_u;
                wr = 1'b1;
            end
            rv_pkg::OPC7_AUIPC: begin
                result = model_pc + imm_u;
                wr = 1'b1;
            end
            rv_pkg::OPC7_JAL: begin
                result = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
                wr = 1'b1;
            end
            rv_pkg::OPC7_JALR: begin
                result = model_pc + 32'd4;
                next_pc = (a + imm_i) & 32'hffff_fffe;
                wr = 1'b1;
            end
            rv_pkg::OPC7_BRANCH: begin
                case (inst.r.funct3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next_pc = model_pc + imm_b;
                end
            end
            // loads, stores, system and unknown words change nothing
            default: wr = 1'b0;
        endcase
        if (inst.r.rd == 5'd0) begin
            wr = 1'b0;
        end
        exp.valid = 1'b1;
        exp.pc = model_pc;
        exp.rd = inst.r.rd;
        exp.we = wr;
        exp.value = result;
        if (wr) begin
            model_regs[inst.r.rd] = result;
        end
        model_pc = next_pc;
        return exp;
    endfunction

    task automatic check_field(input string name, input logic [31:0] pc,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s at pc %h: got %h, expected %h", name, pc, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = 32'h0000_0000;
            end
            model_pc = rv_pkg::RESET_PC;
            done = 1'b0;
            errors = 0;
            retired = 0;
            cycles = 0;
        end else if (!done) begin
            cycles++;
            if (retire.valid) begin
                expected = ref_step(model_inst);
                check_field("retire.pc", expected.pc, retire.pc, expected.pc);
                check_field("retire.rd", expected.pc, {27'd0, retire.rd}, {27'd0, expected.rd});
                check_field("retire.we", expected.pc, {31'd0, retire.we}, {31'd0, expected.we});
                // value only means something when a register is written
                if (expected.we) begin
                    check_field("retire.value", expected.pc, retire.value, expected.value);
                end
                retired++;
                if (expected.pc == halt_pc) begin
                    done = 1'b1;
                end
            end
            if (!done && cycles > cycle_limit) begin
                $display("ERROR: program did not reach its final instruction, %0d retired in %0d cycles",
                         retired, cycles);
                errors++;
                done = 1'b1;
            end
        end
    end

endmodule

//--- dv/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS    = 256;
    localparam int PROG_LEN     = 40;
    localparam int HALT_IDX     = PROG_LEN - 1;
    localparam int NUM_TESTS    = 5;
    localparam int RESET_CYCLES = 5;

    logic            clk = 1'b0;
    logic            rst;
    logic [31:0]     imem_addr;
    logic [31:0]     imem_rdata = rv_pkg::INST_NOP;
    rv_pkg::retire_t retire;
    logic [31:0]     imem [0:MEM_WORDS-1];
    logic [31:0]     fetch_addr;
    logic [31:0]     lcg_state;
    logic [31:0]     model_pc;
    logic [31:0]     model_inst;
    logic            done;
    int              test_errors;
    int              retired;
    int              failed_tests;
    int              total_errors;

    always #5 clk = ~clk;

    // registered read, data lands 1 ns after the edge
    always @(posedge clk) begin
        fetch_addr = imem_addr;
        #1;
        imem_rdata = imem[fetch_addr[9:2]];
    end

    assign model_inst = imem[model_pc[9:2]];

    rv_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .retire     (retire)
    );

    rv_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .model_inst  (model_inst),
        .halt_pc     (32'(HALT_IDX * 4)),
        .cycle_limit (PROG_LEN * 8 + 20),
        .model_pc    (model_pc),
        .done        (done),
        .errors      (test_errors),
        .retired     (retired)
    );

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits, the low ones of an lcg repeat quickly
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rand_next();
        return int'({16'd0, r[31:16]} % 32'(n));
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(8));
    endfunction

    function automatic logic [31:0] alu_word(input logic allow_r, input logic [4:0] rd);
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        f3 = 3'(rand_below(8));
        imm = 12'(rand_below(4096));
        alt = (rand_below(2) == 1);
        if (allow_r && rand_below(2) == 0) begin
            alt = alt && (f3 == 3'd0 || f3 == 3'd5);
            return {1'b0, alt, 5'd0, rand_reg(), rand_reg(), f3, rd, rv_pkg::OPC7_R_TYPE};
        end
        if (f3 == 3'd1) begin
            imm[11:5] = 7'd0;
        end else if (f3 == 3'd5) begin
            imm[11:5] = {1'b0, alt, 5'd0};
        end
        return {imm, rand_reg(), f3, rd, rv_pkg::OPC7_I_TYPE};
    endfunction

    // forward target 1 to 4 words ahead, never past the halt word
    function automatic int fwd_words(input int idx);
        int room;
        room = HALT_IDX - idx;
        return 1 + rand_below((room < 4) ? room : 4);
    endfunction

    function automatic logic [31:0] branch_word(input int idx);
        logic [12:0] off;
        int          pick;
        logic [2:0]  f3;
        off = 13'(fwd_words(idx) * 4);
        pick = rand_below(6);
        f3 = (pick < 2) ? 3'(pick) : 3'(pick + 2);
        return {off[12], off[10:5], 5'(1 + rand_below(4)), 5'(1 + rand_below(4)), f3,
                off[4:1], off[11], rv_pkg::OPC7_BRANCH};
    endfunction

    function automatic logic [31:0] jump_word(input int idx);
        logic [20:0] off;
        int          target;
        if (rand_below(2) == 0) begin
            off = 21'(fwd_words(idx) * 4);
            return {off[20], off[10:1], off[11], off[19:12], rand_reg(), rv_pkg::OPC7_JAL};
        end
        // x8 holds 16, odd offsets check that bit 0 is dropped
        target = (idx + fwd_words(idx)) * 4;
        return {12'(target - 16 + rand_below(2)), 5'd8, 3'd0, rand_reg(), rv_pkg::OPC7_JALR};
    endfunction

    function automatic logic [31:0] pick_word(input int kind, input int idx);
        int          roll;
        logic [31:0] r;
        roll = rand_below(10);
        r = rand_next();
        case (kind)
            0: return alu_word(1'b0, rand_reg());
            1: return alu_word(1'b1, rand_reg());
            2: return (roll < 5) ? branch_word(idx) : alu_word(1'b0, rand_reg());
            3: begin
                if (roll < 4) return jump_word(idx);
                if (roll < 6) return {r[31:12], rand_reg(), rv_pkg::OPC7_LUI};
                if (roll < 8) return {r[31:12], rand_reg(), rv_pkg::OPC7_AUIPC};
                return alu_word(1'b1, rand_reg());
            end
            default: begin
                if (roll < 2) return {r[31:7], rv_pkg::OPC7_LOAD};
                if (roll < 4) return {r[31:7], rv_pkg::OPC7_STORE};
                if (roll < 5) return {r[31:7], rv_pkg::OPC7_SYSTEM};
                if (roll < 7) return alu_word(1'b1, 5'd0);
                return alu_word(1'b1, rand_reg());
            end
        endcase
    endfunction

    task automatic build_program(input int kind);
        for (int a = 0; a < MEM_WORDS; a++) begin
            imem[a] = {25'(a) ^ 25'h155_5555, rv_pkg::OPC7_SYSTEM};
        end
        // addi x8, x0, 16 as jalr base
        imem[0] = {12'd16, 5'd0, 3'd0, 5'd8, rv_pkg::OPC7_I_TYPE};
        for (int idx = 1; idx < HALT_IDX; idx++) begin
            imem[idx] = pick_word(kind, idx);
        end
        // jal x0, 0 spins on the last word
        imem[HALT_IDX] = {20'd0, 5'd0, rv_pkg::OPC7_JAL};
    endtask

    function automatic string test_name(input int kind);
        case (kind)
            0: return "seq_flow";
            1: return "alu_random";
            2: return "branches";
            3: return "jumps_upper";
            default: return "no_write";
        endcase
    endfunction

    task automatic run_test(input int kind);
        @(posedge clk);
        #1;
        rst = 1'b1;
        build_program(kind);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (done);
        @(posedge clk);
        #1;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed, %0d instructions retired", test_name(kind), retired);
        end else begin
            failed_tests++;
            $display("%s: FAILED with %0d errors", test_name(kind), test_errors);
        end
    endtask

    initial begin
        rst = 1'b1;
        lcg_state = 32'h95d5;
        failed_tests = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, failed_tests, total_errors);
        if (failed_tests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * PROG_LEN * 8 + 100) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

//--- tb.f
common/rv_pkg.sv
decoder/rv_decoder.sv
verilog/rv_imm_gen.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_core.sv
dv/rv_checker.sv
dv/tb_top.sv

//--- verilog/rv_core.sv
module rv_core (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     imem_rdata,
    output logic [31:0]     imem_addr,
    output rv_pkg::retire_t retire
);

    // fetch
    logic [31:0]   pc;
    logic [31:0]   pc_next;
    // decode
    logic [31:0]   pc_id;
    logic          valid_id;
    rv_pkg::inst_u inst_id;
    rv_pkg::ctrl_t ctrl_id;
    logic [31:0]   rs1_data_id;
    logic [31:0]   rs2_data_id;
    logic [31:0]   imm_id;
    // execute
    rv_pkg::ctrl_t ctrl_ex;
    rv_pkg::inst_u inst_ex;
    logic [31:0]   pc_ex;
    logic [31:0]   rs1_ex;
    logic [31:0]   rs2_ex;
    logic [31:0]   imm_ex;
    logic          valid_ex;
    logic [31:0]   alu_result;
    logic          bc_a_eq_b;
    logic          bc_a_lt_b;
    logic [31:0]   wb_data;
    logic          rf_we;
    // pipeline control
    logic [1:0]    pc_sel;
    logic          stall_if;
    logic          flow_change;
    logic          clear_id;
    logic          clear_ex;

    assign imem_addr = pc;

    always_comb begin
        case (pc_sel)
            rv_pkg::PC_SEL_INC4: pc_next = pc + 32'd4;
            // jalr target may be odd
            rv_pkg::PC_SEL_ALU:  pc_next = {alu_result[31:1], 1'b0};
            default:             pc_next = rv_pkg::RESET_PC;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= rv_pkg::RESET_PC;
        end else if (!stall_if) begin
            pc <= pc_next;
        end
    end

    // memory output register doubles as the decode instruction register
    always_ff @(posedge clk) begin
        pc_id <= pc;
        if (rst) begin
            valid_id <= 1'b0;
        end else begin
            valid_id <= !(clear_id || stall_if || flow_change);
        end
    end

    assign inst_id = valid_id ? imem_rdata : rv_pkg::INST_NOP;

    rv_decoder decoder_i (
        .clk         (clk),
        .rst         (rst),
        .inst_id     (inst_id),
        .inst_ex     (inst_ex),
        .bc_a_eq_b   (bc_a_eq_b),
        .bc_a_lt_b   (bc_a_lt_b),
        .ctrl        (ctrl_id),
        .pc_sel      (pc_sel),
        .stall_if    (stall_if),
        .flow_change (flow_change),
        .clear_id    (clear_id),
        .clear_ex    (clear_ex)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (inst_id.r.rs1),
        .rs2_addr (inst_id.r.rs2),
        .we       (rf_we),
        .rd_addr  (inst_ex.r.rd),
        .wdata    (wb_data),
        .rs1_data (rs1_data_id),
        .rs2_data (rs2_data_id)
    );

    rv_imm_gen imm_gen_i (
        .inst   (inst_id),
        .ig_sel (ctrl_id.ig_sel),
        .imm    (imm_id)
    );

    always_ff @(posedge clk) begin
        ctrl_ex <= ctrl_id;
        inst_ex <= inst_id;
        pc_ex   <= pc_id;
        rs1_ex  <= rs1_data_id;
        rs2_ex  <= rs2_data_id;
        imm_ex  <= imm_id;
        if (rst || clear_ex) begin
            valid_ex <= 1'b0;
        end else begin
            valid_ex <= valid_id;
        end
    end

    rv_execute execute_i (
        .ctrl       (ctrl_ex),
        .pc         (pc_ex),
        .rs1_data   (rs1_ex),
        .rs2_data   (rs2_ex),
        .imm        (imm_ex),
        .alu_result (alu_result),
        .bc_a_eq_b  (bc_a_eq_b),
        .bc_a_lt_b  (bc_a_lt_b)
    );

    // link address for jumps
    assign wb_data = (ctrl_ex.wb_sel == rv_pkg::WB_SEL_INC4) ? pc_ex + 32'd4 : alu_result;
    assign rf_we   = valid_ex && ctrl_ex.reg_we;

    always_ff @(posedge clk) begin
        retire.pc    <= pc_ex;
        retire.rd    <= inst_ex.r.rd;
        retire.we    <= rf_we;
        retire.value <= wb_data;
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= valid_ex;
        end
    end

    // fetch, decode and execute are all still empty
    a_no_early_retire: assert property (
        @(posedge clk) $fell(rst) |=> !retire.valid [*2]
    );

endmodule

//--- verilog/rv_execute.sv
module rv_execute (
    input  rv_pkg::ctrl_t ctrl,
    input  logic [31:0]   pc,
    input  logic [31:0]   rs1_data,
    input  logic [31:0]   rs2_data,
    input  logic [31:0]   imm,
    output logic [31:0]   alu_result,
    output logic          bc_a_eq_b,
    output logic          bc_a_lt_b
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;

    assign op_a  = (ctrl.alu_a_sel == rv_pkg::ALU_A_SEL_PC)  ? pc  : rs1_data;
    assign op_b  = (ctrl.alu_b_sel == rv_pkg::ALU_B_SEL_IMM) ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
            rv_pkg::ALU_SLT:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_result = {31'd0, op_a < op_b};
            rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            rv_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:     alu_result = op_a | op_b;
            rv_pkg::ALU_AND:    alu_result = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_result = op_b;
            default:            alu_result = 32'h0000_0000;
        endcase
    end

    // comparator always sees the register operands
    assign bc_a_eq_b = (rs1_data == rs2_data);

    always_comb begin
        if (ctrl.bc_uns) begin
            bc_a_lt_b = (rs1_data < rs2_data);
        end else begin
            bc_a_lt_b = ($signed(rs1_data) < $signed(rs2_data));
        end
    end

endmodule

//--- verilog/rv_imm_gen.sv
module rv_imm_gen (
    input  rv_pkg::inst_u inst,
    input  logic [2:0]    ig_sel,
    output logic [31:0]   imm
);

    always_comb begin
        case (ig_sel)
            rv_pkg::IG_I_TYPE: begin
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            end
            rv_pkg::IG_S_TYPE: begin
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            end
            rv_pkg::IG_B_TYPE: begin
                // bit 0 is implicit
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            rv_pkg::IG_U_TYPE: begin
                imm = {inst.u.imm_31_12, 12'h000};
            end
            rv_pkg::IG_J_TYPE: begin
                imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            default: begin
                imm = 32'h0000_0000;
            end
        endcase
    end

endmodule

//--- verilog/rv_regfile.sv
module rv_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic        we,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] wdata,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    // x0 is not stored
    logic [31:0] regs [1:31];

    // same-cycle write is forwarded to decode
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] data;
        if (addr == 5'd0) begin
            data = 32'h0000_0000;
        end else if (we && (addr == rd_addr)) begin
            data = wdata;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (we) begin
            regs[rd_addr] <= wdata;
        end
    end

    // decoder drops reg_we for rd == x0
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        we |-> (rd_addr != 5'd0)
    );

endmodule
